//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the tcu_dot testbench with Verilator.
# Exit status is 0 only when the simulation log reports a pass.

cd "$(dirname "$0")" || exit 1

TOP=tb_tcu_dot
OBJ=obj_dir
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --assert -f verilog.f --top-module "$TOP" --Mdir "$OBJ" -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$OBJ/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
    echo "result: pass"
    exit 0
fi
echo "result: fail"
exit 1

//--- tb_clock_gen.sv
/*
  Free-running clock of period 10. Reset is held low for 8 rising edges and
  released on a falling edge, away from the DUT's sampling edge.
*/
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- tb_tcu_dot.sv
/*
  Reads tcu_dot_golden.txt from the working directory, so run from the project
  root. The out_ack delays are pseudo-random but the same on every run.
*/
`include "tcu_macros.svh"

module tb_tcu_dot import tcu_pkg::*; ();

    localparam int WAIT_LIMIT  = 200;
    localparam int IDLE_CYCLES = 30;

    logic                   clk;
    logic                   rst_n;
    logic                   in_req;
    tcu_req_t               in_data;
    logic                   in_ack;
    logic                   out_req;
    logic [`TCU_ACC_W-1:0]  out_data;
    logic                   out_ack;

    tcu_req_t               vec_req [$];
    logic [`TCU_ACC_W-1:0]  vec_exp [$];
    logic [`TCU_ACC_W-1:0]  exp_q [$];
    logic [31:0]            rnd_state;
    int                     pass_cnt;
    int                     fail_cnt;
    bit                     aborted;

    tb_clock_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    tcu_dot_top uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_req   (in_req),
        .in_data  (in_data),
        .in_ack   (in_ack),
        .out_req  (out_req),
        .out_data (out_data),
        .out_ack  (out_ack)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic string fmt_name(input tcu_fmt_e f);
        case (f)
            FMT_I8:  return "I8";
            FMT_U8:  return "U8";
            FMT_I4:  return "I4";
            default: return "U4";
        endcase
    endfunction

    task automatic load_vectors();
        int          fd;
        int          r;
        string       line;
        logic [31:0] col [11];
        tcu_req_t    req;
        fd = $fopen("tcu_dot_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open tcu_dot_golden.txt");
            fail_cnt++;
            return;
        end
        while (!$feof(fd)) begin
            r = $fgets(line, fd);
            if (r == 0) break;
            // Column description lines
            if (line.getc(0) == "#") continue;
            r = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", col[0], col[1], col[2],
                        col[3], col[4], col[5], col[6], col[7], col[8], col[9], col[10]);
            if (r == 11) begin
                req.fmt = tcu_fmt_e'(col[0][1:0]);
                for (int i = 0; i < `TCU_LANES; i++) begin
                    req.a_row[i] = col[1 + i];
                    req.b_col[i] = col[5 + i];
                end
                req.c = col[9];
                vec_req.push_back(req);
                vec_exp.push_back(col[10]);
            end else if (r > 0) begin
                $display("golden file line could not be read: %s", line);
                fail_cnt++;
            end
        end
        $fclose(fd);
        if (vec_req.size() == 0) begin
            $display("golden file holds no test vectors");
            fail_cnt++;
        end
    endtask

    // Nothing was sent, so out_req must stay low for the whole window
    task automatic check_idle_after_reset();
        bit seen;
        seen = 1'b0;
        for (int cnt = 0; cnt < IDLE_CYCLES; cnt++) begin
            @(negedge clk);
            if (out_req) seen = 1'b1;
        end
        if (seen) begin
            $display("out_req rose after reset although no request was sent");
            fail_cnt++;
        end else begin
            $display("test idle: no result before any request, ok");
            pass_cnt++;
        end
    endtask

    // Starts and ends on a falling edge
    task automatic send_request(input tcu_req_t req, input int idx);
        int cnt;
        in_data = req;
        in_req  = 1'b1;
        cnt = 0;
        while (!in_ack && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        in_req = 1'b0;
        if (!in_ack) begin
            $display("timeout: in_ack did not rise for request %0d", idx);
            fail_cnt++;
            aborted = 1'b1;
            return;
        end
        cnt = 0;
        while (in_ack && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (in_ack) begin
            $display("timeout: in_ack did not drop after request %0d", idx);
            fail_cnt++;
            aborted = 1'b1;
        end
    endtask

    task automatic drive_all();
        for (int i = 0; i < vec_req.size(); i++) begin
            if (aborted) break;
            exp_q.push_back(vec_exp[i]);
            send_request(vec_req[i], i);
        end
    endtask

    task automatic collect_all();
        int                    cnt;
        logic [`TCU_ACC_W-1:0] exp_val;
        for (int i = 0; i < vec_exp.size(); i++) begin
            if (aborted) break;
            cnt = 0;
            while (!out_req && cnt < WAIT_LIMIT) begin
                @(negedge clk);
                cnt++;
            end
            if (!out_req) begin
                $display("timeout: no result arrived for test %0d", i);
                fail_cnt++;
                aborted = 1'b1;
                break;
            end
            if (exp_q.size() == 0) begin
                $display("result arrived at %0t with no request outstanding", $time);
                fail_cnt++;
            end else begin
                exp_val = exp_q.pop_front();
                if (out_data !== exp_val) begin
                    $display("mismatch at %0t: out_data expected %h actual %h (test %0d %s)",
                             $time, exp_val, out_data, i, fmt_name(vec_req[i].fmt));
                    fail_cnt++;
                end else begin
                    $display("test %0d %s: out_data %h ok", i, fmt_name(vec_req[i].fmt),
                             out_data);
                    pass_cnt++;
                end
            end
            // Hold the ack back 0 to 3 cycles so the pipeline backs up
            rnd_state = lcg_next(rnd_state);
            repeat (rnd_state[17:16]) @(negedge clk);
            out_ack = 1'b1;
            cnt = 0;
            while (out_req && cnt < WAIT_LIMIT) begin
                @(negedge clk);
                cnt++;
            end
            out_ack = 1'b0;
            if (out_req) begin
                $display("timeout: out_req did not drop after test %0d", i);
                fail_cnt++;
                aborted = 1'b1;
                break;
            end
        end
    endtask

    // Each result must arrive exactly once
    task automatic check_no_extra();
        bit seen;
        seen = 1'b0;
        for (int cnt = 0; cnt < IDLE_CYCLES; cnt++) begin
            @(negedge clk);
            if (out_req) seen = 1'b1;
        end
        if (seen) begin
            $display("an extra result appeared after the last expected one");
            fail_cnt++;
        end else if (exp_q.size() != 0) begin
            $display("%0d results never arrived", exp_q.size());
            fail_cnt++;
        end else begin
            $display("test tail: no extra result, ok");
            pass_cnt++;
        end
    endtask

    initial begin : main
        int cnt;
        in_req    = 1'b0;
        in_data   = '0;
        out_ack   = 1'b0;
        rnd_state = 32'hea15_d133;
        pass_cnt  = 0;
        fail_cnt  = 0;
        aborted   = 1'b0;
        load_vectors();
        cnt = 0;
        @(negedge clk);
        while (!rst_n && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (!rst_n) begin
            $display("reset was never released");
            fail_cnt++;
        end else begin
            check_idle_after_reset();
            fork
                drive_all();
                collect_all();
            join
            check_no_extra();
        end
        $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- tcu_dot_golden.txt
# fmt a0 a1 a2 a3 b0 b1 b2 b3 c expected, all hex; fmt 0=I8 1=U8 2=I4 3=U4
# expected = c + sum of element products of a[i] and b[i], modulo 2^32
0 80808080 00000000 00000000 00000000 80808080 00000000 00000000 00000000 00000000 00010000
0 7F80FF01 00000000 00000000 00000000 02037F05 00000000 00000000 00000000 00000100 00000004
0 000000FF 00000000 00000000 00000000 00000001 00000000 00000000 00000000 00000000 FFFFFFFF
0 01020304 FEFEFEFE 80000000 0000007F 01010101 03030303 7F000000 00000080 12345678 1233D76A
0 80808080 80808080 80808080 80808080 80808080 80808080 80808080 80808080 00000001 00040001
1 FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFF0000 000EE010
1 000000FF 00000000 00000000 00000000 00000002 00000000 00000000 00000000 FFFFFF00 000000FE
1 01020304 000000FF 00000000 00000000 05060708 000000FF 00000000 00000000 00000000 0000FE47
1 00000000 00000000 00000000 00FF0000 00000000 00000000 00000000 00FF0000 FFFF0200 00000001
0 000000F7 00000000 00000000 00000000 000000F3 00000000 00000000 00000000 00000000 00000075
2 000000F7 00000000 00000000 00000000 000000F3 00000000 00000000 00000000 00000000 00000016
3 000000F7 00000000 00000000 00000000 000000F3 00000000 00000000 00000000 00000000 000000F6
2 88888888 00000000 00000000 00000000 77777777 00000000 00000000 00000000 00000000 FFFFFE40
3 88888888 00000000 00000000 00000000 77777777 00000000 00000000 00000000 00000000 000001C0
2 FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF 00000010 00000030
3 FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF 00000000 00001C20
2 12345678 00000000 00000000 00000000 11111111 00000000 00000000 00000000 00000100 00000114
3 12345678 00000000 00000000 00000000 11111111 00000000 00000000 00000000 00000100 00000124
0 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 DEADBEEF DEADBEEF
1 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
2 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 FFFFFFFF FFFFFFFF
3 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 13579BDF 13579BDF

//--- tcu_dot_top.sv
/*
  Integer dot-product unit, I8/U8/I4/U4 only. Four-phase handshake on both
  sides, up to three requests in flight, results in request order.
*/
`include "tcu_macros.svh"

module tcu_dot_top import tcu_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_req,
    input  tcu_req_t                in_data,
    output logic                    in_ack,
    output logic                    out_req,
    output logic [`TCU_ACC_W-1:0]   out_data,
    input  logic                    out_ack
);

    logic                           stall;
    logic                           lane_valid;
    tcu_lane_in_t [`TCU_LANES-1:0]  lane_in;
    logic [`TCU_ACC_W-1:0]          c_pipe;
    logic [`TCU_LANES-1:0]          lane_ov;
    tcu_psum_t [`TCU_LANES-1:0]     psum;

    tcu_operand_dispatch u_dispatch (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_req     (in_req),
        .in_data    (in_data),
        .in_ack     (in_ack),
        .stall      (stall),
        .lane_valid (lane_valid),
        .lane_in    (lane_in),
        .c_pipe     (c_pipe)
    );

    for (genvar i = 0; i < `TCU_LANES; i++) begin : g_lane
        tcu_int_lane u_lane (
            .clk       (clk),
            .rst_n     (rst_n),
            .stall     (stall),
            .in_valid  (lane_valid),
            .lane_in   (lane_in[i]),
            .out_valid (lane_ov[i]),
            .psum      (psum[i])
        );
    end

    // Lanes step together, so lane 0 speaks for all of them
    tcu_result_reduce u_reduce (
        .clk        (clk),
        .rst_n      (rst_n),
        .psum_valid (lane_ov[0]),
        .psum       (psum),
        .c_pipe     (c_pipe),
        .stall      (stall),
        .out_req    (out_req),
        .out_data   (out_data),
        .out_ack    (out_ack)
    );

endmodule

//--- tcu_int_lane.sv
/*
  One lane: dot product of one a word and one b word, four bytes or eight
  nibbles. Result is registered and held while stall is high.
*/
`include "tcu_macros.svh"

module tcu_int_lane import tcu_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          stall,
    input  logic          in_valid,
    input  tcu_lane_in_t  lane_in,
    output logic          out_valid,
    output tcu_psum_t     psum
);

    localparam int EL8 = `TCU_WORD_W / 8;
    localparam int EL4 = `TCU_WORD_W / 4;

    tcu_word_u  a_w;
    tcu_word_u  b_w;
    logic       is_signed;
    logic       is_nib;
    tcu_psum_t  p8 [EL8];
    tcu_psum_t  p4 [EL4];
    tcu_psum_t  sum8;
    tcu_psum_t  sum4;
    tcu_psum_t  psum_d;

    assign a_w = lane_in.a;
    assign b_w = lane_in.b;

    assign is_signed = (lane_in.fmt == FMT_I8) || (lane_in.fmt == FMT_I4);
    assign is_nib    = (lane_in.fmt == FMT_I4) || (lane_in.fmt == FMT_U4);

    // Byte view: magnitude multiply, sign restored afterwards
    for (genvar j = 0; j < EL8; j++) begin : g_i8
        logic [7:0]  va, vb, ma, mb;
        logic [15:0] prod;
        logic        neg;
        assign va   = a_w.e8[j];
        assign vb   = b_w.e8[j];
        // -128 gives 8'h80, which is 128 read as unsigned
        assign ma   = (is_signed && va[7]) ? 8'(-va) : va;
        assign mb   = (is_signed && vb[7]) ? 8'(-vb) : vb;
        assign prod = ma * mb;
        assign neg  = is_signed && (va[7] ^ vb[7]);
        assign p8[j] = neg ? -tcu_psum_t'(prod) : tcu_psum_t'(prod);
    end

    // Nibble view of the same words
    for (genvar j = 0; j < EL4; j++) begin : g_i4
        logic [3:0] va, vb, ma, mb;
        logic [7:0] prod;
        logic       neg;
        assign va   = a_w.e4[j];
        assign vb   = b_w.e4[j];
        assign ma   = (is_signed && va[3]) ? 4'(-va) : va;
        assign mb   = (is_signed && vb[3]) ? 4'(-vb) : vb;
        assign prod = ma * mb;
        assign neg  = is_signed && (va[3] ^ vb[3]);
        assign p4[j] = neg ? -tcu_psum_t'(prod) : tcu_psum_t'(prod);
    end

    always_comb begin
        sum8 = '0;
        for (int j = 0; j < EL8; j++) begin
            sum8 = sum8 + p8[j];
        end
        sum4 = '0;
        for (int j = 0; j < EL4; j++) begin
            sum4 = sum4 + p4[j];
        end
        psum_d = is_nib ? sum4 : sum8;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (!stall) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && in_valid) begin
            psum <= psum_d;
        end
    end

    a_fmt_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        in_valid |-> !$isunknown(lane_in.fmt)
    );

endmodule

//--- tcu_macros.svh
/*
  Sizing for the integer dot-product unit. TCU_PSUM_W must hold the sum of
  four 8-bit or eight 4-bit products of one word pair, with sign.
*/
`ifndef TCU_MACROS_SVH
`define TCU_MACROS_SVH

// Operand word pairs per request, one lane each
`define TCU_LANES 4

// One packed operand word
`define TCU_WORD_W 32

// Signed partial sum of one lane
`define TCU_PSUM_W 20

// Accumulator term and result, wraps modulo 2^32
`define TCU_ACC_W 32

`endif

//--- tcu_operand_dispatch.sv
/*
  Input side of the unit. Sender must keep in_data stable while in_req is high
  and must not raise in_req again before in_ack has dropped.
*/
`include "tcu_macros.svh"

module tcu_operand_dispatch import tcu_pkg::*; (
    input  logic                              clk,
    input  logic                              rst_n,

    input  logic                              in_req,
    input  tcu_req_t                          in_data,
    output logic                              in_ack,

    input  logic                              stall,
    output logic                              lane_valid,
    output tcu_lane_in_t [`TCU_LANES-1:0]     lane_in,
    output logic [`TCU_ACC_W-1:0]             c_pipe
);

    tcu_req_t req_q;
    logic     take;

    // New request only when the handshake is idle and the register frees up
    assign take = in_req && !in_ack && (!lane_valid || !stall);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_ack <= 1'b0;
        end else if (take) begin
            in_ack <= 1'b1;
        end else if (!in_req) begin
            // Return to zero once the sender has let go
            in_ack <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_valid <= 1'b0;
        end else if (take) begin
            lane_valid <= 1'b1;
        end else if (!stall) begin
            lane_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            req_q <= in_data;
        end
    end

    // Fan out one word pair per lane, format copied to each
    always_comb begin
        for (int i = 0; i < `TCU_LANES; i++) begin
            lane_in[i].fmt = req_q.fmt;
            lane_in[i].a   = req_q.a_row[i];
            lane_in[i].b   = req_q.b_col[i];
        end
    end

    assign c_pipe = req_q.c;

    // An ack edge must answer a request that was present at the capture edge
    a_ack_follows_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(in_ack) |-> $past(in_req)
    );

endmodule

//--- tcu_pkg.sv
/*
  Types shared by the dispatcher, lanes and reducer.
  Only integer formats exist; fmt encoding is fixed by the golden data.
*/
`include "tcu_macros.svh"

package tcu_pkg;

    // Element format of one request
    typedef enum logic [1:0] {
        FMT_I8 = 2'd0,
        FMT_U8 = 2'd1,
        FMT_I4 = 2'd2,
        FMT_U4 = 2'd3
    } tcu_fmt_e;

    // The same word seen as bytes or as nibbles, element 0 in the low bits
    typedef union packed {
        logic [`TCU_WORD_W/8-1:0][7:0] e8;
        logic [`TCU_WORD_W/4-1:0][3:0] e4;
    } tcu_word_u;

    // Full request as carried by the input handshake
    typedef struct packed {
        tcu_fmt_e                    fmt;
        tcu_word_u [`TCU_LANES-1:0]  a_row;
        tcu_word_u [`TCU_LANES-1:0]  b_col;
        logic [`TCU_ACC_W-1:0]       c;
    } tcu_req_t;

    // One word pair for one lane
    typedef struct packed {
        tcu_fmt_e  fmt;
        tcu_word_u a;
        tcu_word_u b;
    } tcu_lane_in_t;

    typedef logic signed [`TCU_PSUM_W-1:0] tcu_psum_t;

endpackage

//--- tcu_result_reduce.sv
/*
  Sums lane results and c modulo 2^32 and sends them on out_req/out_ack.
  Receiver must hold out_ack high until out_req drops.
*/
`include "tcu_macros.svh"

module tcu_result_reduce import tcu_pkg::*; (
    input  logic                           clk,
    input  logic                           rst_n,

    input  logic                           psum_valid,
    input  tcu_psum_t [`TCU_LANES-1:0]     psum,
    input  logic [`TCU_ACC_W-1:0]          c_pipe,
    output logic                           stall,

    output logic                           out_req,
    output logic [`TCU_ACC_W-1:0]          out_data,
    input  logic                           out_ack
);

    localparam int ACC_W = `TCU_ACC_W;

    logic [ACC_W-1:0] c_q;
    logic [ACC_W-1:0] sum_d;
    logic             busy;

    // Holding a result until the whole four-phase transfer is over
    assign stall = busy;

    // c rides alongside the lane registers so it lines up with psum
    always_ff @(posedge clk) begin
        if (!busy) begin
            c_q <= c_pipe;
        end
    end

    always_comb begin
        sum_d = c_q;
        for (int i = 0; i < `TCU_LANES; i++) begin
            sum_d = sum_d + ACC_W'(psum[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && psum_valid) begin
            out_data <= sum_d;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            out_req <= 1'b0;
        end else if (!busy) begin
            if (psum_valid) begin
                busy    <= 1'b1;
                out_req <= 1'b1;
            end
        end else if (out_req) begin
            if (out_ack) begin
                out_req <= 1'b0;
            end
        end else if (!out_ack) begin
            // Ack has returned to zero, transfer done
            busy <= 1'b0;
        end
    end

    a_data_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (out_req && !out_ack) |=> $stable(out_data)
    );

endmodule

//--- verilog.f
+incdir+.
tcu_pkg.sv
tcu_operand_dispatch.sv
tcu_int_lane.sv
tcu_result_reduce.sv
tcu_dot_top.sv
tb_clock_gen.sv
tb_tcu_dot.sv
